// File: hdl/chiplet_types_pkg.sv
package chiplet_types_pkg;

    localparam int NUM_SLOTS      = 4;
    localparam int SLOT_WORDS     = 256;
    localparam int SLOT_ADDR_W    = $clog2(SLOT_WORDS);
    localparam int BUF_WORDS      = NUM_SLOTS * SLOT_WORDS;
    localparam int BUF_ADDR_W     = $clog2(BUF_WORDS);
    localparam int PKT_MAX_LENGTH = 131; // long write, 128 data words
    localparam int LENGTH_W       = $clog2(PKT_MAX_LENGTH + 1);

    localparam int AXI_ADDR_W = 13;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] TX_BUF_BASE    = 13'h0000; // window up to 0x0fff
    localparam logic [AXI_ADDR_W-1:0] TX_SEND_ADDR   = 13'h1000;
    localparam logic [AXI_ADDR_W-1:0] TX_STATUS_ADDR = 13'h1004;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic [$clog2(NUM_SLOTS)-1:0] pkt_id_t;
    typedef logic [4:0] node_id_t;

    typedef enum logic [2:0] {
        FMT_LONG_READ,
        FMT_LONG_WRITE,
        FMT_MEM_RESP,
        FMT_MSG,
        FMT_SWITCH_CFG,
        FMT_SHORT_READ,
        FMT_SHORT_WRITE
    } pkt_fmt_e;

    typedef struct packed {
        pkt_fmt_e   format;
        node_id_t   dest;
        logic [7:0] tag;
        logic [8:0] rsvd;
        logic [6:0] length; // 0 means 128
    } long_hdr_t;

    typedef struct packed {
        pkt_fmt_e   format;
        node_id_t   dest;
        logic [7:0] tag;
        logic [8:0] rsvd;
        logic [6:0] length;
    } resp_hdr_t;

    typedef struct packed {
        pkt_fmt_e   format;
        node_id_t   dest;
        logic [7:0] msg_code;
        logic [8:0] rsvd;
        logic [6:0] length;
    } msg_hdr_t;

    typedef struct packed {
        pkt_fmt_e    format;
        node_id_t    dest;
        logic [19:0] addr;
        logic [3:0]  length; // 0 means 16
    } short_hdr_t;

    typedef struct packed {
        pkt_fmt_e    format;
        logic [28:0] rsvd;
    } switch_cfg_hdr_t;

    typedef struct packed {
        logic        vc;
        pkt_id_t     id;
        node_id_t    req;
        logic [31:0] payload;
    } flit_t;

    typedef struct packed {
        logic    valid;
        pkt_id_t id;
    } send_req_t;

endpackage

// File: hdl/axil_tx_regs.sv
`timescale 1ns/1ps

module axil_tx_regs (
    input  logic                                     clk,
    input  logic                                     n_rst,
    input  logic [chiplet_types_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                                     awvalid,
    output logic                                     awready,
    input  logic [chiplet_types_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [chiplet_types_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic                                     wvalid,
    output logic                                     wready,
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  logic                                     bready,
    input  logic [chiplet_types_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                                     arvalid,
    output logic                                     arready,
    output logic [chiplet_types_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  logic                                     rready,
    output logic                                     wr_en,
    output logic [chiplet_types_pkg::BUF_ADDR_W-1:0] wr_addr,
    output logic [31:0]                              wr_data,
    output chiplet_types_pkg::send_req_t             send_req,
    input  logic                                     busy
);
    import chiplet_types_pkg::*;

    logic wr_hs;
    logic rd_hs;
    logic in_buf;
    logic is_send;

    assign wr_hs   = awvalid && wvalid && !bvalid; // aw and w taken together
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign rd_hs   = arvalid && arready;

    assign in_buf  = awaddr[AXI_ADDR_W-1:BUF_ADDR_W+2] ==
                     TX_BUF_BASE[AXI_ADDR_W-1:BUF_ADDR_W+2];
    assign is_send = awaddr == TX_SEND_ADDR;

    // any set strobe writes the whole word
    assign wr_en   = wr_hs && in_buf && (|wstrb);
    assign wr_addr = awaddr[BUF_ADDR_W+1:2];
    assign wr_data = wdata;

    assign send_req.valid = wr_hs && is_send && wstrb[0] && !busy;
    assign send_req.id    = wdata[$bits(pkt_id_t)-1:0];

    assign rresp = RESP_OKAY;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
            bresp  <= (is_send && busy) ? RESP_SLVERR : RESP_OKAY; // doorbell while busy
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_hs) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (!rvalid || rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= (araddr == TX_STATUS_ADDR) ? AXI_DATA_W'(busy) : '0;
        end
    end

endmodule

// File: hdl/tx_pkt_buffer.sv
`timescale 1ns/1ps

module tx_pkt_buffer (
    input  logic                                     clk,
    input  logic                                     wr_en,
    input  logic [chiplet_types_pkg::BUF_ADDR_W-1:0] wr_addr,
    input  logic [31:0]                              wr_data,
    input  logic                                     rd_en,
    input  logic [chiplet_types_pkg::BUF_ADDR_W-1:0] rd_addr,
    output logic [31:0]                              rd_data
);
    import chiplet_types_pkg::*;

    logic [31:0] mem [BUF_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // output holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hdl/tx_fsm.sv
`timescale 1ns/1ps

module tx_fsm (
    input  logic                                     clk,
    input  logic                                     n_rst,
    input  chiplet_types_pkg::send_req_t             send_req,
    input  chiplet_types_pkg::node_id_t              node_id,
    output logic                                     busy,
    output logic                                     rd_en,
    output logic [chiplet_types_pkg::BUF_ADDR_W-1:0] rd_addr,
    input  logic [31:0]                              rd_data,
    output chiplet_types_pkg::flit_t                 in_flit,
    output logic                                     in_valid,
    input  logic                                     in_ready
);
    import chiplet_types_pkg::*;

    typedef enum logic [1:0] {
        IDLE, LOAD, HDR, SEND
    } state_e;

    state_e              state, next_state;
    pkt_id_t             cur_id;
    logic [LENGTH_W-1:0] word_cnt, word_idx;
    logic [LENGTH_W-1:0] pkt_len, hdr_len;
    logic                last_word;
    long_hdr_t           long_hdr;
    resp_hdr_t           resp_hdr;
    msg_hdr_t            msg_hdr;
    short_hdr_t          short_hdr;
    switch_cfg_hdr_t     switch_cfg_hdr;

    function automatic logic [LENGTH_W-1:0] long_data(input logic [6:0] field);
        return (field == '0) ? LENGTH_W'(128) : LENGTH_W'(field);
    endfunction

    function automatic logic [LENGTH_W-1:0] short_data(input logic [3:0] field);
        return (field == '0) ? LENGTH_W'(16) : LENGTH_W'(field);
    endfunction

    assign busy      = state != IDLE;
    assign in_valid  = state == SEND;
    assign last_word = word_cnt == pkt_len - LENGTH_W'(1);

    assign in_flit.vc      = 1'b0;
    assign in_flit.id      = cur_id;
    assign in_flit.req     = node_id;
    assign in_flit.payload = rd_data;

    // header views of the word read at the doorbell
    always_comb begin
        long_hdr       = long_hdr_t'(rd_data);
        resp_hdr       = resp_hdr_t'(rd_data);
        msg_hdr        = msg_hdr_t'(rd_data);
        short_hdr      = short_hdr_t'(rd_data);
        switch_cfg_hdr = switch_cfg_hdr_t'(rd_data);

        case (switch_cfg_hdr.format)
            FMT_LONG_READ:   hdr_len = LENGTH_W'(3); // header + address + crc
            FMT_LONG_WRITE:  hdr_len = LENGTH_W'(3) + long_data(long_hdr.length);
            FMT_MEM_RESP:    hdr_len = LENGTH_W'(2) + long_data(resp_hdr.length);
            FMT_MSG:         hdr_len = LENGTH_W'(2) + long_data(msg_hdr.length);
            FMT_SWITCH_CFG:  hdr_len = LENGTH_W'(1);
            FMT_SHORT_READ:  hdr_len = LENGTH_W'(2);
            FMT_SHORT_WRITE: hdr_len = LENGTH_W'(2) + short_data(short_hdr.length);
            default:         hdr_len = LENGTH_W'(1); // unknown format, header only
        endcase
    end

    always_comb begin
        next_state = state;
        rd_en      = 1'b0;
        word_idx   = word_cnt;

        case (state)
            IDLE: begin
                if (send_req.valid) begin
                    next_state = LOAD;
                    rd_en      = 1'b1; // header read
                end
            end
            LOAD: next_state = HDR;
            HDR:  next_state = SEND;
            SEND: begin
                if (in_ready) begin
                    if (last_word) begin
                        next_state = IDLE;
                    end else begin
                        rd_en    = 1'b1;
                        word_idx = word_cnt + LENGTH_W'(1);
                    end
                end
            end
            default: next_state = IDLE;
        endcase

        if (state == IDLE) begin
            rd_addr = {send_req.id, SLOT_ADDR_W'(0)};
        end else begin
            rd_addr = {cur_id, SLOT_ADDR_W'(word_idx)}; // slot start + word
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= IDLE;
            cur_id   <= '0;
            word_cnt <= '0;
            pkt_len  <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE) begin
                word_cnt <= '0;
                if (send_req.valid) begin
                    cur_id <= send_req.id;
                end
            end else begin
                word_cnt <= word_idx;
            end
            if (state == HDR) begin
                pkt_len <= hdr_len;
            end
        end
    end

endmodule

// File: hdl/flit_skid_buffer.sv
`timescale 1ns/1ps

module flit_skid_buffer (
    input  logic                     clk,
    input  logic                     n_rst,
    input  chiplet_types_pkg::flit_t in_flit,
    input  logic                     in_valid,
    output logic                     in_ready,
    output chiplet_types_pkg::flit_t flit,
    output logic                     flit_valid,
    input  logic                     buffer_full
);
    import chiplet_types_pkg::*;

    flit_t      entry [2];
    logic [1:0] count, next_count;
    logic       push, pop;

    assign push       = in_valid && in_ready;
    assign pop        = flit_valid && !buffer_full;
    assign flit       = entry[0]; // head
    assign flit_valid = count != 2'd0;
    assign next_count = count + 2'(push) - 2'(pop);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count    <= 2'd0;
            in_ready <= 1'b1;
        end else begin
            count    <= next_count;
            in_ready <= next_count != 2'd2; // low only when both full
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            if (count == 2'd2) begin
                entry[0] <= entry[1];
                if (push) begin
                    entry[1] <= in_flit;
                end
            end else if (push) begin
                entry[0] <= in_flit;
            end
        end else if (push) begin
            if (count == 2'd0) begin
                entry[0] <= in_flit;
            end else begin
                entry[1] <= in_flit;
            end
        end
    end

endmodule

// File: hdl/chiplet_tx_top.sv
`timescale 1ns/1ps

module chiplet_tx_top (
    input  logic                                       clk,
    input  logic                                       n_rst,
    input  chiplet_types_pkg::node_id_t                node_id,
    input  logic [chiplet_types_pkg::AXI_ADDR_W-1:0]   awaddr,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [chiplet_types_pkg::AXI_DATA_W-1:0]   wdata,
    input  logic [chiplet_types_pkg::AXI_DATA_W/8-1:0] wstrb,
    input  logic                                       wvalid,
    output logic                                       wready,
    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    input  logic [chiplet_types_pkg::AXI_ADDR_W-1:0]   araddr,
    input  logic                                       arvalid,
    output logic                                       arready,
    output logic [chiplet_types_pkg::AXI_DATA_W-1:0]   rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  logic                                       rready,
    output chiplet_types_pkg::flit_t                   flit,
    output logic                                       flit_valid,
    input  logic                                       buffer_full
);
    import chiplet_types_pkg::*;

    logic                  wr_en;
    logic [BUF_ADDR_W-1:0] wr_addr;
    logic [31:0]           wr_data;
    send_req_t             send_req;
    logic                  busy;
    logic                  rd_en;
    logic [BUF_ADDR_W-1:0] rd_addr;
    logic [31:0]           rd_data;
    flit_t                 in_flit;
    logic                  in_valid;
    logic                  in_ready;

    axil_tx_regs u_regs (
        .clk      (clk),
        .n_rst    (n_rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .send_req (send_req),
        .busy     (busy)
    );

    tx_pkt_buffer u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    tx_fsm u_fsm (
        .clk      (clk),
        .n_rst    (n_rst),
        .send_req (send_req),
        .node_id  (node_id),
        .busy     (busy),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .in_flit  (in_flit),
        .in_valid (in_valid),
        .in_ready (in_ready)
    );

    flit_skid_buffer u_skid (
        .clk         (clk),
        .n_rst       (n_rst),
        .in_flit     (in_flit),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .flit        (flit),
        .flit_valid  (flit_valid),
        .buffer_full (buffer_full)
    );

endmodule

// File: verification/tb_chiplet_tx_sva.sv
`timescale 1ns/1ps

module tb_chiplet_tx_sva (
    input logic                     clk,
    input logic                     n_rst,
    input chiplet_types_pkg::flit_t flit,
    input logic                     flit_valid,
    input logic                     buffer_full,
    input logic                     bvalid,
    input logic                     bready,
    input logic                     busy
);

    // switch full, head flit must wait unchanged
    flit_stable_a: assert property (@(posedge clk) disable iff (!n_rst)
        flit_valid && buffer_full |=> flit_valid && $stable(flit))
        else $error("flit changed while the switch was full");

    bvalid_hold_a: assert property (@(posedge clk) disable iff (!n_rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    reset_quiet_a: assert property (@(posedge clk)
        !n_rst |-> !flit_valid && !busy)
        else $error("flit_valid or busy high during reset");

endmodule

bind chiplet_tx_top tb_chiplet_tx_sva u_sva (
    .clk         (clk),
    .n_rst       (n_rst),
    .flit        (flit),
    .flit_valid  (flit_valid),
    .buffer_full (buffer_full),
    .bvalid      (bvalid),
    .bready      (bready),
    .busy        (busy)
);

// File: verification/tb_chiplet_tx.sv
`timescale 1ns/1ps

module tb_chiplet_tx;
    import chiplet_types_pkg::*;

    localparam int NUM_RANDOM = 16;
    localparam int NUM_PKTS   = 7 + 4 + 1 + 1 + NUM_RANDOM;

    logic                    clk = 1'b0;
    logic                    n_rst;
    node_id_t                node_id;
    logic [AXI_ADDR_W-1:0]   awaddr, araddr;
    logic [AXI_DATA_W-1:0]   wdata, rdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    awvalid, wvalid, bready, arvalid, rready;
    logic                    awready, wready, bvalid, arready, rvalid;
    logic [1:0]              bresp, rresp;
    flit_t                   flit;
    logic                    flit_valid;
    logic                    buffer_full;

    logic [15:0] lfsr_state = 16'd61;
    logic [31:0] model_mem [BUF_WORDS];
    flit_t       exp_q [$];
    flit_t       exp_flit;
    logic        bp_on = 1'b0;
    logic        bp_next;
    int          flit_count = 0;
    int          flit_errors = 0;
    int          resp_errors = 0;

    chiplet_tx_top u_chiplet_tx_top (.*);

    always #4 clk = ~clk; // 8 ns period

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hb400;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    // words in a packet, from format and length field
    function automatic int pkt_words(input logic [31:0] hdr);
        int data7;
        int data4;
        data7 = (hdr[6:0] == 7'd0) ? 128 : int'(hdr[6:0]);
        data4 = (hdr[3:0] == 4'd0) ? 16 : int'(hdr[3:0]);
        case (hdr[31:29])
            3'd0:       return 3;
            3'd1:       return 3 + data7;
            3'd2, 3'd3: return 2 + data7;
            3'd4:       return 1;
            3'd5:       return 2;
            3'd6:       return 2 + data4;
            default:    return 1;
        endcase
    endfunction

    task automatic axi_write(input logic [12:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic stall;
        stall   = rand_bits(2) == 2'b00; // sometimes keep the response waiting
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = !stall;
        do @(negedge clk); while (!awready);
        if (wready !== 1'b1) begin
            $display("CHECK FAILED wready expected 0x1 actual 0x%h", wready);
            resp_errors++;
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        if (stall) begin
            @(posedge clk);
            #1;
            bready = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic axi_read(input logic [12:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        if (rresp !== RESP_OKAY) begin
            $display("CHECK FAILED rresp expected 0x%h actual 0x%h", RESP_OKAY, rresp);
            resp_errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_read(input logic [12:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        axi_read(addr, data);
        if (data !== expected) begin
            $display("CHECK FAILED rdata at 0x%h expected 0x%h actual 0x%h",
                     addr, expected, data);
            resp_errors++;
        end
    endtask

    task automatic write_expect(input logic [12:0] addr, input logic [31:0] data,
                                input logic [1:0] expected);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        if (resp !== expected) begin
            $display("CHECK FAILED bresp at 0x%h expected 0x%h actual 0x%h",
                     addr, expected, resp);
            resp_errors++;
        end
    endtask

    task automatic buf_write(input int word, input logic [31:0] data);
        write_expect(TX_BUF_BASE + 13'(word * 4), data, RESP_OKAY);
        model_mem[word] = data;
    endtask

    // fill a slot and queue the flits it should produce
    task automatic load_packet(input logic [2:0] fmt, input logic [6:0] field,
                               input pkt_id_t slot, output int len);
        logic [31:0] hdr;
        int          base;
        flit_t       f;
        hdr        = rand_bits(32);
        hdr[31:29] = fmt;
        hdr[6:0]   = field;
        len        = pkt_words(hdr);
        base       = int'(slot) * SLOT_WORDS;
        buf_write(base, hdr);
        for (int i = 1; i < len; i++) begin
            buf_write(base + i, rand_bits(32));
        end
        for (int i = 0; i < len; i++) begin
            f.vc      = 1'b0;
            f.id      = slot;
            f.req     = node_id;
            f.payload = model_mem[base + i];
            exp_q.push_back(f);
        end
    endtask

    // poll until the engine is idle, then let the skid stage drain
    task automatic finish_packet(input int start, input int len);
        logic [31:0] status;
        status = 32'd1;
        while (status[0]) begin
            axi_read(TX_STATUS_ADDR, status);
        end
        if (status !== 32'd0) begin
            $display("CHECK FAILED status expected 0x%h actual 0x%h", 32'd0, status);
            resp_errors++;
        end
        while (flit_valid) begin
            @(posedge clk);
            #1;
        end
        if (flit_count - start != len) begin
            $display("CHECK FAILED flit count expected 0x%h actual 0x%h",
                     len, flit_count - start);
            flit_errors++;
        end
    endtask

    task automatic send_packet(input logic [2:0] fmt, input logic [6:0] field,
                               input logic bp);
        pkt_id_t slot;
        int      len;
        int      start;
        slot = pkt_id_t'(rand_bits(2));
        load_packet(fmt, field, slot, len);
        bp_on = bp;
        start = flit_count;
        write_expect(TX_SEND_ADDR, 32'(slot), RESP_OKAY);
        finish_packet(start, len);
        bp_on = 1'b0;
    endtask

    // switch back-pressure, drawn at negedge
    initial begin
        buffer_full = 1'b0;
        forever begin
            @(negedge clk);
            bp_next = 1'b0;
            if (bp_on) begin
                bp_next = rand_bits(2) == 2'b11;
            end
            @(posedge clk);
            #1;
            buffer_full = bp_next;
        end
    end

    always @(negedge clk) begin
        if (n_rst && flit_valid && !buffer_full) begin
            flit_count++;
            if (exp_q.size() == 0) begin
                $display("unexpected flit with payload 0x%h while no packet was pending",
                         flit.payload);
                flit_errors++;
            end else begin
                exp_flit = exp_q.pop_front();
                if (flit.vc !== exp_flit.vc) begin
                    $display("CHECK FAILED flit.vc expected 0x%h actual 0x%h",
                             exp_flit.vc, flit.vc);
                    flit_errors++;
                end
                if (flit.id !== exp_flit.id) begin
                    $display("CHECK FAILED flit.id expected 0x%h actual 0x%h",
                             exp_flit.id, flit.id);
                    flit_errors++;
                end
                if (flit.req !== exp_flit.req) begin
                    $display("CHECK FAILED flit.req expected 0x%h actual 0x%h",
                             exp_flit.req, flit.req);
                    flit_errors++;
                end
                if (flit.payload !== exp_flit.payload) begin
                    $display("CHECK FAILED flit.payload expected 0x%h actual 0x%h",
                             exp_flit.payload, flit.payload);
                    flit_errors++;
                end
            end
        end
    end

    initial begin
        repeat (NUM_PKTS * 200 + 1000) @(posedge clk);
        $display("run timed out after %0d cycles", NUM_PKTS * 200 + 1000);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        pkt_id_t busy_slot;
        int      len;
        int      start;
        n_rst   = 1'b1;
        node_id = node_id_t'(rand_bits(5));
        awaddr  = '0;
        wdata   = '0;
        wstrb   = 4'hf;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        #1;
        n_rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;

        for (int f = 0; f < 7; f++) begin
            send_packet(3'(f), 7'(rand_bits(7)), 1'b0);
        end
        send_packet(3'd1, 7'd0, 1'b0); // zero field means max
        send_packet(3'd2, 7'd0, 1'b0);
        send_packet(3'd3, 7'd0, 1'b0);
        send_packet(3'd6, 7'd0, 1'b0);

        busy_slot = pkt_id_t'(rand_bits(2));
        load_packet(3'd1, 7'd40, busy_slot, len);
        start = flit_count;
        write_expect(TX_SEND_ADDR, 32'(busy_slot), RESP_OKAY);
        check_read(TX_STATUS_ADDR, 32'd1);
        write_expect(TX_SEND_ADDR, 32'(busy_slot + 2'd1), RESP_SLVERR);
        finish_packet(start, len);

        load_packet(3'd1, 7'd8, 2'd0, len); // low words of slot 0 sit under the aliases
        write_expect(13'h1008, rand_bits(32), RESP_OKAY);
        write_expect(13'h1ffc, rand_bits(32), RESP_OKAY);
        write_expect(TX_STATUS_ADDR, rand_bits(32), RESP_OKAY);
        start = flit_count;
        write_expect(TX_SEND_ADDR, 32'd0, RESP_OKAY);
        finish_packet(start, len);
        check_read(13'h1008, 32'd0);
        check_read(13'h0040, 32'd0); // buffer is write only
        check_read(TX_SEND_ADDR, 32'd0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_packet(3'(rand_bits(3) % 7), 7'(rand_bits(7)), 1'b1);
        end

        $display("flit errors %0d, response errors %0d, flits checked %0d",
                 flit_errors, resp_errors, flit_count);
        if (flit_errors == 0 && resp_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: chiplet_tx.f
hdl/chiplet_types_pkg.sv
hdl/axil_tx_regs.sv
hdl/tx_pkt_buffer.sv
hdl/tx_fsm.sv
hdl/flit_skid_buffer.sv
hdl/chiplet_tx_top.sv
verification/tb_chiplet_tx_sva.sv
verification/tb_chiplet_tx.sv

// File: Bender.yml
package:
  name: chiplet_tx

sources:
  - files:
      - hdl/chiplet_types_pkg.sv
      - hdl/axil_tx_regs.sv
      - hdl/tx_pkt_buffer.sv
      - hdl/tx_fsm.sv
      - hdl/flit_skid_buffer.sv
      - hdl/chiplet_tx_top.sv
  - target: test
    files:
      - verification/tb_chiplet_tx_sva.sv
      - verification/tb_chiplet_tx.sv
